//--- logic/coprocessor0.sv
`timescale 1ns/10ps
`default_nettype none

module coprocessor0 import memPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  memOp              op,
    input  logic [31:0]       pc,
    input  logic [31:0]       writeData,
    input  logic [4:0]        regId,
    input  logic              inDelaySlot,
    input  logic [5:0]        hwInt,
    input  excCode            exc,
    output memPkg::kernelCtrl kernelCtrl,
    output logic              takeTrap,
    output logic              excBranchDelay,
    output logic [29:0]       epc,
    output logic [31:0]       readData
);

    // Status fields
    logic [5:0] intMask;
    logic       exl;
    logic       ie;

    // Cause fields
    logic [5:0] intPendingBits;
    logic [4:0] causeCode;
    logic       branchDelay;

    logic [31:0] epcReg;

    logic [31:0] statusWord;
    logic [31:0] causeWord;
    logic        intTaken;
    logic        excTaken;

    assign statusWord = {16'b0, intMask, 8'b0, exl, ie};
    assign causeWord  = {branchDelay, 15'b0, intPendingBits, 3'b0, causeCode, 2'b0};

    // Interrupts only while enabled and not already in the handler
    assign intTaken = (|(hwInt & intMask)) && ie && !exl;
    assign excTaken = (exc != excNone);
    assign takeTrap = intTaken || excTaken;

    always_comb begin
        if (takeTrap) begin
            kernelCtrl = kcEnter;
        end else if (op == opEret) begin
            kernelCtrl = kcEret;
        end else begin
            kernelCtrl = kcNone;
        end
    end

    assign excBranchDelay = takeTrap && inDelaySlot;
    assign epc            = epcReg[31:2];

    always_comb begin
        case (regId)
            cp0Status: readData = statusWord;
            cp0Cause:  readData = causeWord;
            cp0Epc:    readData = epcReg;
            cp0PrId:   readData = prIdValue;
            default:   readData = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            intMask        <= 6'b111111;
            exl            <= 1'b0;
            ie             <= 1'b1;
            intPendingBits <= 6'b0;
            causeCode      <= 5'd0;
            branchDelay    <= 1'b0;
            epcReg         <= textStart;
        end else begin
            // IP mirrors the interrupt lines
            intPendingBits <= hwInt;
            if (takeTrap) begin
                exl         <= 1'b1;
                causeCode   <= intTaken ? excInt : exc;
                branchDelay <= inDelaySlot;
                // Return to the branch when the victim sits in its delay slot
                epcReg      <= inDelaySlot ? (pc - 32'd4) : pc;
            end else if (op == opEret) begin
                exl         <= 1'b0;
                causeCode   <= 5'd0;
                branchDelay <= 1'b0;
            end else if (op == opMtc0) begin
                if (regId == cp0Status) begin
                    {intMask, exl, ie} <= {writeData[15:10], writeData[1], writeData[0]};
                end else if (regId == cp0Epc) begin
                    epcReg <= writeData;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/dataMemory.sv
`timescale 1ns/10ps
`default_nettype none

module dataMemory import memPkg::*; (
    input  logic        clk,
    input  logic [29:0] addr,
    input  logic [3:0]  writeEnable,
    input  logic [31:0] writeData,
    output logic [31:0] readData
);

    logic [31:0] mem [dataWords];
    logic [dataAddrBits-1:0] wordIndex;

    assign wordIndex = addr[dataAddrBits-1:0];

    // One enable per byte lane
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (writeEnable[lane]) begin
                mem[wordIndex][8*lane +: 8] <= writeData[8*lane +: 8];
            end
        end
    end

    assign readData = mem[wordIndex];

endmodule

`default_nettype wire

//--- logic/memPkg.sv
`default_nettype none

package memPkg;

    // Operation carried down the pipe with each instruction
    typedef enum logic [3:0] {
        opNone,
        opAlu,
        opLw,
        opLh,
        opLhu,
        opLb,
        opLbu,
        opSw,
        opSh,
        opSb,
        opMfc0,
        opMtc0,
        opEret
    } memOp;

    // Cause codes; excNone sits outside the architectural code range
    typedef enum logic [4:0] {
        excInt  = 5'd0,
        excAdEL = 5'd4,
        excAdES = 5'd5,
        excRi   = 5'd10,
        excOv   = 5'd12,
        excNone = 5'd31
    } excCode;

    typedef enum logic [1:0] {
        kcNone,
        kcEnter,
        kcEret
    } kernelCtrl;

    typedef struct packed {
        memOp        op;
        logic [31:0] pc;
        excCode      exc;
        logic        inDelaySlot;
        logic [31:0] aluResult;
        logic [31:0] rtData;
        logic [4:0]  rtAddr;
        logic [4:0]  rdAddr;
        logic [4:0]  destAddr;
        logic [31:0] destData;
    } memStageIn;

    typedef struct packed {
        memOp        op;
        logic [31:0] memWord;
        logic [1:0]  offset;
        logic [4:0]  destAddr;
        logic [31:0] destData;
    } wbStageIn;

    typedef struct packed {
        logic [4:0]  destAddr;
        logic [31:0] destData;
    } wbResult;

    // Address map
    localparam logic [31:0] dataStart = 32'h0000_0000;
    localparam logic [31:0] dataEnd   = 32'h0000_2FFF;
    localparam logic [31:0] textStart = 32'h0000_3000;

    localparam int dataWords    = 3072;
    localparam int dataAddrBits = $clog2(dataWords);

    // Coprocessor register ids
    localparam logic [4:0] cp0Status = 5'd12;
    localparam logic [4:0] cp0Cause  = 5'd13;
    localparam logic [4:0] cp0Epc    = 5'd14;
    localparam logic [4:0] cp0PrId   = 5'd15;

    localparam logic [31:0] prIdValue = 32'h1D2C_3B4A;

endpackage

`default_nettype wire

//--- logic/memStage.sv
`timescale 1ns/10ps
`default_nettype none

module memStage import memPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  logic              clr,
    input  memStageIn         stageIn,
    input  logic [4:0]        fwdAddr,
    input  logic [31:0]       fwdData,
    input  logic [5:0]        hwInt,
    output logic [29:0]       memAddr,
    output logic [3:0]        memWriteEnable,
    output logic [31:0]       memWriteData,
    input  logic [31:0]       memReadData,
    output wbStageIn          wbOut,
    output memPkg::kernelCtrl kernelCtrl,
    output logic [29:0]       epc,
    output logic              excBranchDelay
);

    logic [31:0] rtValue;
    logic [3:0]  byteEnable;
    logic [31:0] laneData;
    excCode      alignExc;
    excCode      finalExc;
    logic        takeTrap;
    logic [31:0] cp0Data;
    logic        isLoad;
    wbStageIn    wbNext;

    // Writeback bypass into the store data
    // Register 0 never forwards
    assign rtValue = ((fwdAddr == stageIn.rtAddr) && (fwdAddr != 5'd0)) ?
                     fwdData : stageIn.rtData;

    storeAlign storeAlign_i (
        .op         (stageIn.op),
        .addr       (stageIn.aluResult),
        .storeData  (rtValue),
        .byteEnable (byteEnable),
        .laneData   (laneData),
        .exc        (alignExc)
    );

    // Earlier stages take priority
    assign finalExc = (stageIn.exc != excNone) ? stageIn.exc : alignExc;

    coprocessor0 coprocessor0_i (
        .clk            (clk),
        .reset          (reset),
        .op             (stageIn.op),
        .pc             (stageIn.pc),
        .writeData      (rtValue),
        .regId          (stageIn.rdAddr),
        .inDelaySlot    (stageIn.inDelaySlot),
        .hwInt          (hwInt),
        .exc            (finalExc),
        .kernelCtrl     (kernelCtrl),
        .takeTrap       (takeTrap),
        .excBranchDelay (excBranchDelay),
        .epc            (epc),
        .readData       (cp0Data)
    );

    assign memAddr        = stageIn.aluResult[31:2];
    assign memWriteData   = laneData;
    assign memWriteEnable = (takeTrap || stall) ? 4'b0000 : byteEnable;

    assign isLoad = (stageIn.op == opLw) || (stageIn.op == opLh) || (stageIn.op == opLhu) ||
                    (stageIn.op == opLb) || (stageIn.op == opLbu);

    always_comb begin
        wbNext.op       = stageIn.op;
        wbNext.memWord  = memReadData;
        wbNext.offset   = stageIn.aluResult[1:0];
        wbNext.destAddr = stageIn.destAddr;
        if (stageIn.op == opMfc0) begin
            wbNext.destData = cp0Data;
        end else if (isLoad) begin
            wbNext.destData = memReadData;
        end else begin
            wbNext.destData = stageIn.destData;
        end
        // Trapped instruction becomes a bubble
        if (takeTrap) begin
            wbNext = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clr) begin
            wbOut <= '0;
        end else if (!stall) begin
            wbOut <= wbNext;
        end
    end

endmodule

`default_nettype wire

//--- logic/memSubsystem.sv
`timescale 1ns/10ps
`default_nettype none

module memSubsystem import memPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  logic              clr,
    input  memStageIn         stageIn,
    input  logic [4:0]        fwdAddr,
    input  logic [31:0]       fwdData,
    input  logic [5:0]        hwInt,
    output wbResult           result,
    output memPkg::kernelCtrl kernelCtrl,
    output logic [29:0]       epc,
    output logic              excBranchDelay
);

    logic [29:0] memAddr;
    logic [3:0]  memWriteEnable;
    logic [31:0] memWriteData;
    logic [31:0] memReadData;
    wbStageIn    wbReg;

    memStage memStage_i (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .clr            (clr),
        .stageIn        (stageIn),
        .fwdAddr        (fwdAddr),
        .fwdData        (fwdData),
        .hwInt          (hwInt),
        .memAddr        (memAddr),
        .memWriteEnable (memWriteEnable),
        .memWriteData   (memWriteData),
        .memReadData    (memReadData),
        .wbOut          (wbReg),
        .kernelCtrl     (kernelCtrl),
        .epc            (epc),
        .excBranchDelay (excBranchDelay)
    );

    dataMemory dataMemory_i (
        .clk         (clk),
        .addr        (memAddr),
        .writeEnable (memWriteEnable),
        .writeData   (memWriteData),
        .readData    (memReadData)
    );

    writebackStage writebackStage_i (
        .clk    (clk),
        .reset  (reset),
        .wbIn   (wbReg),
        .result (result)
    );

endmodule

`default_nettype wire

//--- logic/storeAlign.sv
`timescale 1ns/10ps
`default_nettype none

module storeAlign import memPkg::*; (
    input  memOp        op,
    input  logic [31:0] addr,
    input  logic [31:0] storeData,
    output logic [3:0]  byteEnable,
    output logic [31:0] laneData,
    output excCode      exc
);

    logic isLoad;
    logic isStore;
    logic misaligned;
    logic outOfWindow;

    assign isLoad  = (op == opLw) || (op == opLh) || (op == opLhu) ||
                     (op == opLb) || (op == opLbu);
    assign isStore = (op == opSw) || (op == opSh) || (op == opSb);

    // Word needs both low bits clear and halfword only bit 0
    always_comb begin
        misaligned = 1'b0;
        if ((op == opLw) || (op == opSw)) begin
            misaligned = (addr[1:0] != 2'b00);
        end else if ((op == opLh) || (op == opLhu) || (op == opSh)) begin
            misaligned = addr[0];
        end
    end

    // Unsigned wrap of the offset catches addresses below the window
    assign outOfWindow = (addr - dataStart) > (dataEnd - dataStart);

    always_comb begin
        byteEnable = 4'b0000;
        laneData   = storeData;
        case (op)
            opSw: begin
                byteEnable = 4'b1111;
            end
            opSh: begin
                byteEnable = 4'b0011 << {addr[1], 1'b0};
                laneData   = storeData << {addr[1], 4'b0000};
            end
            opSb: begin
                byteEnable = 4'b0001 << addr[1:0];
                laneData   = storeData << {addr[1:0], 3'b000};
            end
            default: begin
                byteEnable = 4'b0000;
            end
        endcase
    end

    always_comb begin
        exc = excNone;
        if (isLoad && (misaligned || outOfWindow)) begin
            exc = excAdEL;
        end else if (isStore && (misaligned || outOfWindow)) begin
            exc = excAdES;
        end
    end

endmodule

`default_nettype wire

//--- logic/writebackStage.sv
`timescale 1ns/10ps
`default_nettype none

module writebackStage import memPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  wbStageIn wbIn,
    output wbResult  result
);

    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    logic [31:0] wbValue;

    // Shift the addressed lane down to bit 0
    assign loadByte = 8'(wbIn.memWord >> {wbIn.offset, 3'b000});
    assign loadHalf = 16'(wbIn.memWord >> {wbIn.offset[1], 4'b0000});

    always_comb begin
        case (wbIn.op)
            opLw:    wbValue = wbIn.memWord;
            opLh:    wbValue = {{16{loadHalf[15]}}, loadHalf};
            opLhu:   wbValue = {16'b0, loadHalf};
            opLb:    wbValue = {{24{loadByte[7]}}, loadByte};
            opLbu:   wbValue = {24'b0, loadByte};
            default: wbValue = wbIn.destData;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else begin
            result.destAddr <= wbIn.destAddr;
            result.destData <= wbValue;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module memSubsystemTb -o memSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0

//--- tests/memChecker.sv
`timescale 1ns/10ps
`default_nettype none

module memChecker import memPkg::*; (
    input  logic        clk,
    input  logic        finish,
    input  wbResult     dutResult,
    input  kernelCtrl   dutKernelCtrl,
    input  logic [29:0] dutEpc,
    input  logic        dutBranchDelay,
    input  logic        expValid,
    input  logic [7:0]  expTest,
    input  kernelCtrl   expKernelCtrl,
    input  logic        expBranchDelay,
    input  wbResult     expResult,
    input  logic [29:0] expEpc,
    output logic        busy,
    output int          errorCount
);

    // Result and epc of a line due two cycles after it was presented
    typedef struct packed {
        logic [7:0]  test;
        int          dueCycle;
        wbResult     res;
        logic [29:0] epc;
    } delayedCheck;

    delayedCheck pending[$];
    int testErrors[int];
    int cycle = 0;
    int errors = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    logic pendingLeft = 1'b0;

    assign busy       = pendingLeft;
    assign errorCount = errors;

    task automatic compareValue(input string name, input logic [7:0] test,
                                input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch %s in test %0d: got %h, expected %h", name, test, got, expected);
            errors = errors + 1;
            testErrors[int'(test)] = testErrors[int'(test)] + 1;
        end
    endtask

    task automatic reportTestDone(input logic [7:0] test);
        if (testErrors[int'(test)] == 0) begin
            $display("Test %0d passed", test);
            testsPassed = testsPassed + 1;
        end else begin
            $display("Test %0d failed with %0d mismatches", test, testErrors[int'(test)]);
            testsFailed = testsFailed + 1;
        end
    endtask

    // Sampled mid-cycle when all outputs have settled
    always @(negedge clk) begin
        delayedCheck entry;
        cycle = cycle + 1;
        if (expValid) begin
            if (!testErrors.exists(int'(expTest))) begin
                testErrors[int'(expTest)] = 0;
            end
            compareValue("kernelCtrl", expTest, 32'(dutKernelCtrl), 32'(expKernelCtrl));
            compareValue("excBranchDelay", expTest, 32'(dutBranchDelay), 32'(expBranchDelay));
            entry.test     = expTest;
            entry.dueCycle = cycle + 2;
            entry.res      = expResult;
            entry.epc      = expEpc;
            pending.push_back(entry);
        end
        if ((pending.size() > 0) && (pending[0].dueCycle == cycle)) begin
            entry = pending.pop_front();
            compareValue("result.destAddr", entry.test, 32'(dutResult.destAddr),
                         32'(entry.res.destAddr));
            compareValue("result.destData", entry.test, dutResult.destData, entry.res.destData);
            compareValue("epc", entry.test, 32'(dutEpc), 32'(entry.epc));
            // Last line of a test has been checked
            if ((pending.size() == 0) || (pending[0].test != entry.test)) begin
                reportTestDone(entry.test);
            end
        end
        pendingLeft = (pending.size() != 0);
    end

    always @(posedge finish) begin
        $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d",
                 testsPassed, testsFailed, errors);
    end

endmodule

`default_nettype wire

//--- tests/memStim.txt
# test stall clr hwInt op pc exc ds alu rtData rtAddr rdAddr destAddr destData fwdAddr fwdData
# then expected kernelCtrl excBranchDelay resultAddr resultData epc, all fields hex
1 0 0 00 7 00003000 1f 0 00000100 11223344 08 00 00 00000000 00 00000000 0 0 00 00000000 c00
1 0 0 00 8 00003004 1f 0 00000102 0000aabb 08 00 00 00000000 00 00000000 0 0 00 00000000 c00
1 0 0 00 9 00003008 1f 0 00000101 000000cc 08 00 00 00000000 00 00000000 0 0 00 00000000 c00
1 0 0 00 2 0000300c 1f 0 00000100 00000000 00 00 02 00000000 00 00000000 0 0 02 aabbcc44 c00
1 0 0 00 3 00003010 1f 0 00000102 00000000 00 00 03 00000000 00 00000000 0 0 03 ffffaabb c00
1 0 0 00 4 00003014 1f 0 00000102 00000000 00 00 04 00000000 00 00000000 0 0 04 0000aabb c00
1 0 0 00 5 00003018 1f 0 00000101 00000000 00 00 05 00000000 00 00000000 0 0 05 ffffffcc c00
1 0 0 00 6 0000301c 1f 0 00000100 00000000 00 00 06 00000000 00 00000000 0 0 06 00000044 c00
1 0 0 00 5 00003020 1f 0 00000103 00000000 00 00 07 00000000 00 00000000 0 0 07 ffffffaa c09
2 0 0 00 2 00003024 1f 0 00000102 00000000 00 00 09 00000000 00 00000000 1 0 00 00000000 c0a
2 0 0 00 7 00003028 1f 0 00000102 55555555 08 00 00 00000000 00 00000000 1 0 00 00000000 c0b
2 0 0 00 9 0000302c 1f 0 00003000 00000077 08 00 00 00000000 00 00000000 1 0 00 00000000 c0b
2 0 0 00 2 00003030 1f 0 00000100 00000000 00 00 0a 00000000 00 00000000 0 0 0a aabbcc44 c0b
3 0 0 00 7 00003034 1f 0 00000104 12345678 09 00 00 00000000 09 cafef00d 0 0 00 00000000 c0b
3 0 0 00 7 00003038 1f 0 00000108 0badc0de 00 00 00 00000000 00 ffffffff 0 0 00 00000000 c0b
3 0 0 00 2 0000303c 1f 0 00000104 00000000 00 00 0b 00000000 00 00000000 0 0 0b cafef00d c0b
3 0 0 00 2 00003040 1f 0 00000108 00000000 00 00 0c 00000000 00 00000000 0 0 0c 0badc0de c0b
4 0 0 00 c 00003044 1f 0 00000000 00000000 00 00 00 00000000 00 00000000 2 0 00 00000000 c0b
4 0 0 00 b 00003048 1f 0 00000000 00000401 03 0c 00 00000000 00 00000000 0 0 00 00000000 c0b
4 0 0 02 1 0000304c 1f 0 00000000 00000000 00 00 0d 00000099 00 00000000 0 0 0d 00000099 c13
4 0 0 01 1 00003050 1f 1 00000000 00000000 00 00 0e 00000077 00 00000000 1 1 00 00000000 c13
4 0 0 00 c 00003054 1f 0 00000000 00000000 00 00 00 00000000 00 00000000 2 0 00 00000000 c13
4 0 0 00 a 00003058 1f 0 00000000 00000000 00 0c 0f 00000000 00 00000000 0 0 0f 00000401 1000
5 0 0 00 b 0000305c 1f 0 00000000 00004000 03 0e 00 00000000 00 00000000 0 0 00 00000000 1000
5 0 0 00 a 00003060 1f 0 00000000 00000000 00 0e 10 00000000 00 00000000 0 0 10 00004000 1000
5 0 0 00 a 00003064 1f 0 00000000 00000000 00 0f 11 00000000 00 00000000 0 0 11 1d2c3b4a 1000
6 0 0 00 1 00003068 1f 0 00000000 00000000 00 00 12 000000a1 00 00000000 0 0 12 000000a1 1000
6 1 0 00 1 0000306c 1f 0 00000000 00000000 00 00 13 000000b2 00 00000000 0 0 12 000000a1 1000
6 0 0 00 1 00003070 1f 0 00000000 00000000 00 00 14 000000c3 00 00000000 0 0 14 000000c3 1000
6 0 1 00 1 00003074 1f 0 00000000 00000000 00 00 15 000000d4 00 00000000 0 0 00 00000000 1000
6 0 0 00 1 00003078 1f 0 00000000 00000000 00 00 16 000000e5 00 00000000 0 0 16 000000e5 1000

//--- tests/memSubsystemTb.sv
`timescale 1ns/10ps
`default_nettype none

module memSubsystemTb import memPkg::*; ();

    // One stimulus line with the inputs of a cycle and what they should produce
    typedef struct packed {
        logic [7:0]  test;
        logic        stall;
        logic        clr;
        logic [5:0]  hwInt;
        memStageIn   stageIn;
        logic [4:0]  fwdAddr;
        logic [31:0] fwdData;
        kernelCtrl   kc;
        logic        branchDelay;
        wbResult     result;
        logic [29:0] epc;
    } stimLine;

    logic        clk = 1'b0;
    logic        reset;
    logic        stall;
    logic        clr;
    memStageIn   stageIn;
    logic [4:0]  fwdAddr;
    logic [31:0] fwdData;
    logic [5:0]  hwInt;
    wbResult     resultOut;
    kernelCtrl   kernelState;
    logic [29:0] epcOut;
    logic        branchDelayOut;

    logic        expValid;
    logic [7:0]  expTest;
    kernelCtrl   expKc;
    logic        expBd;
    wbResult     expResult;
    logic [29:0] expEpc;
    logic        finish;
    logic        checkerBusy;
    int          errorCount;

    stimLine lines[$];
    int      loadErrors = 0;
    int      cycleLimit = 0;
    int      cycleCount = 0;

    always #4 clk = ~clk;

    memSubsystem memSubsystem_i (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .clr            (clr),
        .stageIn        (stageIn),
        .fwdAddr        (fwdAddr),
        .fwdData        (fwdData),
        .hwInt          (hwInt),
        .result         (resultOut),
        .kernelCtrl     (kernelState),
        .epc            (epcOut),
        .excBranchDelay (branchDelayOut)
    );

    memChecker memChecker_i (
        .clk            (clk),
        .finish         (finish),
        .dutResult      (resultOut),
        .dutKernelCtrl  (kernelState),
        .dutEpc         (epcOut),
        .dutBranchDelay (branchDelayOut),
        .expValid       (expValid),
        .expTest        (expTest),
        .expKernelCtrl  (expKc),
        .expBranchDelay (expBd),
        .expResult      (expResult),
        .expEpc         (expEpc),
        .busy           (checkerBusy),
        .errorCount     (errorCount)
    );

    task automatic loadStimulus();
        int          fd;
        int          count;
        string       text;
        logic [31:0] f [21];
        stimLine     s;
        fd = $fopen("tests/memStim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/memStim.txt");
            loadErrors = loadErrors + 1;
            return;
        end
        while ($fgets(text, fd) != 0) begin
            if ((text.len() > 1) && (text[0] != "#")) begin
                count = $sscanf(text,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
                if (count != 21) begin
                    $display("Stimulus line has %0d fields instead of 21: %s", count, text);
                    loadErrors = loadErrors + 1;
                end else begin
                    s.test                = f[0][7:0];
                    s.stall               = f[1][0];
                    s.clr                 = f[2][0];
                    s.hwInt               = f[3][5:0];
                    s.stageIn.op          = memOp'(f[4][3:0]);
                    s.stageIn.pc          = f[5];
                    s.stageIn.exc         = excCode'(f[6][4:0]);
                    s.stageIn.inDelaySlot = f[7][0];
                    s.stageIn.aluResult   = f[8];
                    s.stageIn.rtData      = f[9];
                    s.stageIn.rtAddr      = f[10][4:0];
                    s.stageIn.rdAddr      = f[11][4:0];
                    s.stageIn.destAddr    = f[12][4:0];
                    s.stageIn.destData    = f[13];
                    s.fwdAddr             = f[14][4:0];
                    s.fwdData             = f[15];
                    s.kc                  = kernelCtrl'(f[16][1:0]);
                    s.branchDelay         = f[17][0];
                    s.result.destAddr     = f[18][4:0];
                    s.result.destData     = f[19];
                    s.epc                 = f[20][29:0];
                    lines.push_back(s);
                end
            end
        end
        $fclose(fd);
    endtask

    // Bubble with no exception and no interrupt lines
    task automatic applyIdle();
        stall         = 1'b0;
        clr           = 1'b0;
        hwInt         = '0;
        stageIn       = '0;
        stageIn.op    = opNone;
        stageIn.exc   = excNone;
        fwdAddr       = '0;
        fwdData       = '0;
        expValid      = 1'b0;
        expTest       = '0;
        expKc         = kcNone;
        expBd         = 1'b0;
        expResult     = '0;
        expEpc        = '0;
    endtask

    task automatic applyLine(input stimLine s);
        stall     = s.stall;
        clr       = s.clr;
        hwInt     = s.hwInt;
        stageIn   = s.stageIn;
        fwdAddr   = s.fwdAddr;
        fwdData   = s.fwdData;
        expValid  = 1'b1;
        expTest   = s.test;
        expKc     = s.kc;
        expBd     = s.branchDelay;
        expResult = s.result;
        expEpc    = s.epc;
    endtask

    initial begin
        reset  = 1'b1;
        finish = 1'b0;
        applyIdle();
        loadStimulus();
        // Lines plus reset plus drain margin
        cycleLimit = lines.size() + 10 + 20;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        foreach (lines[i]) begin
            applyLine(lines[i]);
            @(posedge clk);
            #1;
        end
        applyIdle();
        while (checkerBusy) begin
            @(posedge clk);
            #1;
        end
        finish = 1'b1;
        #1;
        if ((errorCount == 0) && (loadErrors == 0) && (lines.size() > 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, the checker never drained", cycleCount);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/memPkg.sv
logic/storeAlign.sv
logic/coprocessor0.sv
logic/dataMemory.sv
logic/memStage.sv
logic/writebackStage.sv
logic/memSubsystem.sv
tests/memChecker.sv
tests/memSubsystemTb.sv
